//--- compile.f
+incdir+common
common/itcm_pkg.sv
source/itcm_lsu_n2w.sv
itcm_ram/itcm_arbiter.sv
itcm_ram/itcm_sram_ctrl.sv
source/itcm_ctrl.sv
test/itcm_ram_model.sv
test/tb_itcm_ctrl.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = tb_itcm_ctrl
FILELIST  = compile.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- test/tb_itcm_ctrl.sv
// Directed testbench for the ITCM controller
// Drives the IFU and LSU ports, a RAM model sits on the RAM pins
// Read data is compared with a byte-masked reference memory
`timescale 1ns/1ps
`default_nettype none

`include "itcm_defines.svh"

module tb_itcm_ctrl;

  import itcm_pkg::*;

  localparam int CLK_NS      = 40;
  localparam int N_LANE_OPS  = 16;                   // LSU writes in the lane test
  localparam int TOTAL_TRANS = 2 * N_LANE_OPS + 32;  // All transfers, rounded up

  logic clk = 1'b0;
  logic rst;
  integer seed = 32'h35fa8472;

  // IFU port
  logic                         ifu_cmd_valid, ifu_cmd_ready, ifu_cmd_read;
  logic [`ITCM_ADDR_WIDTH-1:0]  ifu_cmd_addr;
  itcm_word_u                   ifu_cmd_wdata;
  logic [`ITCM_WMSK_WIDTH-1:0]  ifu_cmd_wmask;
  logic                         ifu_rsp_valid, ifu_rsp_ready, ifu_holdup;
  itcm_word_u                   ifu_rsp_rdata;
  // LSU port
  logic                         lsu_cmd_valid, lsu_cmd_ready, lsu_cmd_read;
  logic [`ITCM_ADDR_WIDTH-1:0]  lsu_cmd_addr;
  logic [`LSU_DATA_WIDTH-1:0]   lsu_cmd_wdata;
  logic [`LSU_WMSK_WIDTH-1:0]   lsu_cmd_wmask;
  logic                         lsu_rsp_valid, lsu_rsp_ready;
  logic [`LSU_DATA_WIDTH-1:0]   lsu_rsp_rdata;
  // Status and RAM pins
  logic                         itcm_active, ram_cs, ram_we;
  logic [`ITCM_RAM_AW-1:0]      ram_addr;
  logic [`ITCM_WMSK_WIDTH-1:0]  ram_wem;
  logic [`ITCM_DATA_WIDTH-1:0]  ram_din, ram_dout;

  logic [`ITCM_DATA_WIDTH-1:0]  ref_mem [0:(1 << `ITCM_RAM_AW)-1];  // Expected RAM

  always #(CLK_NS / 2) clk = ~clk;

  itcm_ctrl dut (
    .i_clk (clk), .i_rst (rst),
    .i_ifu_cmd_valid (ifu_cmd_valid), .o_ifu_cmd_ready (ifu_cmd_ready),
    .i_ifu_cmd_addr (ifu_cmd_addr), .i_ifu_cmd_read (ifu_cmd_read),
    .i_ifu_cmd_wdata (ifu_cmd_wdata), .i_ifu_cmd_wmask (ifu_cmd_wmask),
    .o_ifu_rsp_valid (ifu_rsp_valid), .i_ifu_rsp_ready (ifu_rsp_ready),
    .o_ifu_rsp_rdata (ifu_rsp_rdata), .o_ifu_holdup (ifu_holdup),
    .i_lsu_cmd_valid (lsu_cmd_valid), .o_lsu_cmd_ready (lsu_cmd_ready),
    .i_lsu_cmd_addr (lsu_cmd_addr), .i_lsu_cmd_read (lsu_cmd_read),
    .i_lsu_cmd_wdata (lsu_cmd_wdata), .i_lsu_cmd_wmask (lsu_cmd_wmask),
    .o_lsu_rsp_valid (lsu_rsp_valid), .i_lsu_rsp_ready (lsu_rsp_ready),
    .o_lsu_rsp_rdata (lsu_rsp_rdata), .o_itcm_active (itcm_active),
    .o_ram_cs (ram_cs), .o_ram_we (ram_we), .o_ram_addr (ram_addr),
    .o_ram_wem (ram_wem), .o_ram_din (ram_din), .i_ram_dout (ram_dout)
  );

  itcm_ram_model #(.DEPTH(8192)) u_ram (
    .i_clk (clk), .i_cs (ram_cs), .i_we (ram_we), .i_addr (ram_addr),
    .i_wem (ram_wem), .i_din (ram_din), .o_dout (ram_dout)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Reporting and reference helpers
  ////////////////////////////////////////////////////////////////////////////
  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic check_value(input string name, input logic [63:0] exp,
                             input logic [63:0] act);
    assert (act === exp)
      else fail_run($sformatf("Error: %s expected %h actual %h", name, exp, act));
  endtask

  task automatic expect_bit(input string name, input logic exp, input logic act);
    assert (act === exp)
      else fail_run($sformatf("Error: %s expected %b actual %b", name, exp, act));
  endtask

  // Bytes with a mask bit set take the new data
  function automatic logic [63:0] merge_bytes(input logic [63:0] old_word,
                                              input logic [63:0] data,
                                              input logic [7:0] mask);
    logic [63:0] res;
    res = old_word;
    for (int b = 0; b < 8; b++) begin
      if (mask[b]) res[b*8 +: 8] = data[b*8 +: 8];
    end
    return res;
  endfunction

  // Call just after a falling edge, returns within the transfer cycle
  task automatic wait_cmd_ready(input logic from_ifu);
    #1;
    while (!(from_ifu ? ifu_cmd_ready : lsu_cmd_ready)) begin
      @(negedge clk);
      #1;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Port accesses, each one transfer plus its response
  ////////////////////////////////////////////////////////////////////////////
  task automatic lsu_access(input string name, input logic [15:0] addr, input logic rd,
                            input logic [31:0] wdata, input logic [3:0] wmask,
                            output logic [31:0] rdata);
    logic [12:0] idx;
    logic        lane;
    idx           = addr[15:3];
    lane          = addr[2];           // 1 is the upper half
    lsu_cmd_valid = 1'b1;
    lsu_cmd_addr  = addr;
    lsu_cmd_read  = rd;
    lsu_cmd_wdata = wdata;
    lsu_cmd_wmask = wmask;
    wait_cmd_ready(1'b0);
    @(negedge clk);
    lsu_cmd_valid = 1'b0;
    expect_bit({name, " rsp valid"}, 1'b1, lsu_rsp_valid);  // Exactly one cycle later
    rdata = lsu_rsp_rdata;
    if (rd) begin
      check_value(name, {32'd0, lane ? ref_mem[idx][63:32] : ref_mem[idx][31:0]},
                  {32'd0, rdata});
    end else begin
      ref_mem[idx] = merge_bytes(ref_mem[idx], {wdata, wdata},
                                 lane ? {wmask, 4'd0} : {4'd0, wmask});
    end
  endtask

  task automatic ifu_access(input string name, input logic [15:0] addr, input logic rd,
                            input logic [63:0] wdata, input logic [7:0] wmask,
                            output logic [63:0] rdata);
    logic [12:0] idx;
    idx                = addr[15:3];
    ifu_cmd_valid      = 1'b1;
    ifu_cmd_addr       = addr;
    ifu_cmd_read       = rd;
    ifu_cmd_wdata.word = wdata;
    ifu_cmd_wmask      = wmask;
    wait_cmd_ready(1'b1);
    @(negedge clk);
    ifu_cmd_valid = 1'b0;
    expect_bit({name, " rsp valid"}, 1'b1, ifu_rsp_valid);
    rdata = ifu_rsp_rdata.word;
    if (rd) check_value(name, ref_mem[idx], rdata);
    else ref_mem[idx] = merge_bytes(ref_mem[idx], wdata, wmask);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////////////
  task automatic reset_state();
    #1;
    expect_bit("reset lsu_rsp_valid", 1'b0, lsu_rsp_valid);
    expect_bit("reset ifu_rsp_valid", 1'b0, ifu_rsp_valid);
    expect_bit("reset ram_cs", 1'b0, ram_cs);
    expect_bit("reset ifu_holdup", 1'b0, ifu_holdup);
    expect_bit("reset itcm_active", 1'b0, itcm_active);   // No valid driven
    @(negedge clk);
  endtask

  // Full-word IFU writes so later masked merges start from known bytes
  task automatic preload_words();
    logic [63:0] rd64;
    logic [31:0] hi, lo;
    for (int i = 0; i < 9; i++) begin
      hi = $random(seed);
      lo = $random(seed);
      ifu_access("preload", {(i < 8) ? 13'h40 + i[12:0] : 13'h80, 3'd0}, 1'b0,
                 {hi, lo}, 8'hff, rd64);
    end
  endtask

  task automatic lane_write_read();
    logic [15:0] addr_list [N_LANE_OPS];
    logic [31:0] r, d, rd32;
    for (int i = 0; i < N_LANE_OPS; i++) begin
      r            = $random(seed);
      d            = $random(seed);
      addr_list[i] = {13'h40 + {10'd0, r[2:0]}, i[0], 2'b00};  // Both lanes, repeats
      lsu_access("lane write", addr_list[i], 1'b0, d, r[7:4], rd32);
    end
    for (int i = 0; i < N_LANE_OPS; i++) begin
      lsu_access("lane read", addr_list[i], 1'b1, 32'd0, 4'd0, rd32);
    end
  endtask

  task automatic ifu_lane_view();
    logic [63:0] rd64;
    logic [31:0] hi, lo, rd32;
    for (int i = 0; i < 8; i++) begin
      ifu_access("ifu view read", {13'h40 + i[12:0], 3'd0}, 1'b1, 64'd0, 8'd0, rd64);
    end
    hi = $random(seed);
    lo = $random(seed);
    ifu_access("ifu masked write", {13'h80, 3'd0}, 1'b0, {hi, lo}, hi[7:0], rd64);
    lsu_access("lsu low lane", {13'h80, 3'b000}, 1'b1, 32'd0, 4'd0, rd32);
    lsu_access("lsu high lane", {13'h80, 3'b100}, 1'b1, 32'd0, 4'd0, rd32);
  endtask

  task automatic lsu_priority();
    logic [31:0] exp_lsu;
    logic [63:0] exp_ifu;
    exp_lsu       = ref_mem[13'h41][63:32];
    exp_ifu       = ref_mem[13'h80];
    lsu_cmd_valid = 1'b1;          // Both raised on the same edge
    lsu_cmd_addr  = {13'h41, 3'b100};
    lsu_cmd_read  = 1'b1;
    ifu_cmd_valid = 1'b1;
    ifu_cmd_addr  = {13'h80, 3'b000};
    ifu_cmd_read  = 1'b1;
    #1;
    expect_bit("priority lsu cmd ready", 1'b1, lsu_cmd_ready);
    expect_bit("priority ifu cmd ready", 1'b0, ifu_cmd_ready);
    @(negedge clk);
    lsu_cmd_valid = 1'b0;
    expect_bit("priority lsu rsp valid", 1'b1, lsu_rsp_valid);
    check_value("priority lsu rdata", {32'd0, exp_lsu}, {32'd0, lsu_rsp_rdata});
    wait_cmd_ready(1'b1);          // IFU goes once the LSU is served
    @(negedge clk);
    ifu_cmd_valid = 1'b0;
    expect_bit("priority ifu rsp valid", 1'b1, ifu_rsp_valid);
    check_value("priority ifu rdata", exp_ifu, ifu_rsp_rdata.word);
  endtask

  task automatic back_pressure();
    logic [31:0] held;
    logic [63:0] rd64;
    lsu_rsp_ready = 1'b0;
    lsu_cmd_valid = 1'b1;
    lsu_cmd_addr  = {13'h43, 3'b000};
    lsu_cmd_read  = 1'b1;
    wait_cmd_ready(1'b0);
    @(negedge clk);
    lsu_cmd_valid = 1'b0;
    ifu_cmd_valid = 1'b1;          // IFU waits behind the stalled response
    ifu_cmd_addr  = {13'h44, 3'b000};
    ifu_cmd_read  = 1'b1;
    held          = lsu_rsp_rdata;
    check_value("stall rdata", {32'd0, ref_mem[13'h43][31:0]}, {32'd0, held});
    repeat (5) begin
      #1;
      expect_bit("stall lsu rsp valid", 1'b1, lsu_rsp_valid);
      check_value("stall rdata held", {32'd0, held}, {32'd0, lsu_rsp_rdata});
      expect_bit("stall lsu cmd ready", 1'b0, lsu_cmd_ready);
      expect_bit("stall ifu cmd ready", 1'b0, ifu_cmd_ready);
      expect_bit("stall itcm active", 1'b1, itcm_active);
      @(negedge clk);
    end
    lsu_rsp_ready = 1'b1;
    ifu_access("stall release", {13'h44, 3'b000}, 1'b1, 64'd0, 8'd0, rd64);
  endtask

  task automatic holdup_flag();
    logic [31:0] rd32;
    logic [63:0] rd64;
    lsu_access("holdup lsu", {13'h45, 3'b000}, 1'b1, 32'd0, 4'd0, rd32);
    expect_bit("holdup after lsu", 1'b0, ifu_holdup);
    ifu_access("holdup ifu", {13'h46, 3'b000}, 1'b1, 64'd0, 8'd0, rd64);
    expect_bit("holdup after ifu", 1'b1, ifu_holdup);
    repeat (3) begin
      @(negedge clk);
      expect_bit("holdup idle", 1'b1, ifu_holdup);   // No access, word still there
    end
    lsu_access("holdup lsu again", {13'h45, 3'b100}, 1'b1, 32'd0, 4'd0, rd32);
    expect_bit("holdup cleared", 1'b0, ifu_holdup);
  endtask

  initial begin
    rst           = 1'b1;
    ifu_cmd_valid = 1'b0;
    ifu_cmd_addr  = '0;
    ifu_cmd_read  = 1'b0;
    ifu_cmd_wdata = '0;
    ifu_cmd_wmask = '0;
    ifu_rsp_ready = 1'b1;
    lsu_cmd_valid = 1'b0;
    lsu_cmd_addr  = '0;
    lsu_cmd_read  = 1'b0;
    lsu_cmd_wdata = '0;
    lsu_cmd_wmask = '0;
    lsu_rsp_ready = 1'b1;
    fork
      begin
        #((TOTAL_TRANS + 200) * CLK_NS);
        fail_run("Watchdog timeout, a handshake never completed");
      end
    join_none
    repeat (16) @(negedge clk);
    rst = 1'b0;
    reset_state();
    preload_words();
    lane_write_read();
    ifu_lane_view();
    lsu_priority();
    back_pressure();
    holdup_flag();
    @(negedge clk);
    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

//--- test/itcm_ram_model.sv
// Behavioral single-port RAM for simulating the ITCM controller
// Read data shows up one cycle after cs, writes follow the byte mask
// The output keeps the last read word until the next read
`timescale 1ns/1ps
`default_nettype none

`include "itcm_defines.svh"

module itcm_ram_model #(
  parameter int DEPTH = 1 << `ITCM_RAM_AW   // Words
) (
  input  wire                          i_clk,
  input  wire                          i_cs,
  input  wire                          i_we,
  input  wire [`ITCM_RAM_AW-1:0]       i_addr,
  input  wire [`ITCM_WMSK_WIDTH-1:0]   i_wem,
  input  wire [`ITCM_DATA_WIDTH-1:0]   i_din,
  output logic [`ITCM_DATA_WIDTH-1:0]  o_dout
);

  logic [`ITCM_DATA_WIDTH-1:0] mem [0:DEPTH-1];

  always_ff @(posedge i_clk) begin
    if (i_cs && i_we) begin
      for (int b = 0; b < `ITCM_WMSK_WIDTH; b++) begin
        if (i_wem[b]) begin
          mem[i_addr][b*8 +: 8] <= i_din[b*8 +: 8];  // One byte lane
        end
      end
    end else if (i_cs) begin
      o_dout <= mem[i_addr];   // Held while cs stays low
    end
  end

endmodule

`default_nettype wire

//--- source/itcm_ctrl.sv
// ITCM controller top level
// IFU and LSU share one single-port 64-bit RAM, LSU has priority
// Connect the ram pins straight to a RAM macro with 1-cycle read latency
`timescale 1ns/1ps
`default_nettype none

`include "itcm_defines.svh"

module itcm_ctrl (
  input  wire                          i_clk,
  input  wire                          i_rst,
  // IFU command
  input  wire                          i_ifu_cmd_valid,
  output logic                         o_ifu_cmd_ready,
  input  wire [`ITCM_ADDR_WIDTH-1:0]   i_ifu_cmd_addr,
  input  wire                          i_ifu_cmd_read,
  input  wire itcm_pkg::itcm_word_u    i_ifu_cmd_wdata,
  input  wire [`ITCM_WMSK_WIDTH-1:0]   i_ifu_cmd_wmask,
  // IFU response
  output logic                         o_ifu_rsp_valid,
  input  wire                          i_ifu_rsp_ready,
  output itcm_pkg::itcm_word_u         o_ifu_rsp_rdata,
  output logic                         o_ifu_holdup,    // RAM output still holds IFU word
  // LSU command
  input  wire                          i_lsu_cmd_valid,
  output logic                         o_lsu_cmd_ready,
  input  wire [`ITCM_ADDR_WIDTH-1:0]   i_lsu_cmd_addr,
  input  wire                          i_lsu_cmd_read,
  input  wire [`LSU_DATA_WIDTH-1:0]    i_lsu_cmd_wdata,
  input  wire [`LSU_WMSK_WIDTH-1:0]    i_lsu_cmd_wmask,
  // LSU response
  output logic                         o_lsu_rsp_valid,
  input  wire                          i_lsu_rsp_ready,
  output logic [`LSU_DATA_WIDTH-1:0]   o_lsu_rsp_rdata,
  // Status
  output logic                         o_itcm_active,
  // RAM pins
  output logic                         o_ram_cs,
  output logic                         o_ram_we,
  output logic [`ITCM_RAM_AW-1:0]      o_ram_addr,
  output logic [`ITCM_WMSK_WIDTH-1:0]  o_ram_wem,
  output logic [`ITCM_DATA_WIDTH-1:0]  o_ram_din,
  input  wire [`ITCM_DATA_WIDTH-1:0]   i_ram_dout
);

  import itcm_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // LSU in 64-bit lane form
  ////////////////////////////////////////////////////////////////////////////
  logic                        lsu_w_cmd_valid;
  logic                        lsu_w_cmd_ready;
  logic [`ITCM_ADDR_WIDTH-1:0] lsu_w_cmd_addr;
  logic                        lsu_w_cmd_read;
  itcm_word_u                  lsu_w_cmd_wdata;
  logic [`ITCM_WMSK_WIDTH-1:0] lsu_w_cmd_wmask;
  logic                        lsu_w_rsp_valid;
  logic                        lsu_w_rsp_ready;
  itcm_word_u                  lsu_w_rsp_rdata;

  // Arbiter to RAM controller
  logic                        arb_cmd_valid;
  logic                        arb_cmd_ready;
  logic [`ITCM_ADDR_WIDTH-1:0] arb_cmd_addr;
  logic                        arb_cmd_read;
  itcm_word_u                  arb_cmd_wdata;
  logic [`ITCM_WMSK_WIDTH-1:0] arb_cmd_wmask;
  logic                        arb_cmd_ifu;     // Source tag, 1 for IFU
  logic                        arb_rsp_valid;
  logic                        arb_rsp_ready;
  itcm_word_u                  arb_rsp_rdata;
  logic                        arb_rsp_ifu;

  itcm_lsu_n2w u_lsu_n2w (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_cmd_valid (i_lsu_cmd_valid),
    .o_cmd_ready (o_lsu_cmd_ready),
    .i_cmd_addr  (i_lsu_cmd_addr),
    .i_cmd_read  (i_lsu_cmd_read),
    .i_cmd_wdata (i_lsu_cmd_wdata),
    .i_cmd_wmask (i_lsu_cmd_wmask),
    .o_rsp_valid (o_lsu_rsp_valid),
    .i_rsp_ready (i_lsu_rsp_ready),
    .o_rsp_rdata (o_lsu_rsp_rdata),
    .o_cmd_valid (lsu_w_cmd_valid),
    .i_cmd_ready (lsu_w_cmd_ready),
    .o_cmd_addr  (lsu_w_cmd_addr),
    .o_cmd_read  (lsu_w_cmd_read),
    .o_cmd_wdata (lsu_w_cmd_wdata),
    .o_cmd_wmask (lsu_w_cmd_wmask),
    .i_rsp_valid (lsu_w_rsp_valid),
    .o_rsp_ready (lsu_w_rsp_ready),
    .i_rsp_rdata (lsu_w_rsp_rdata)
  );

  itcm_arbiter u_arbiter (
    .i_clk           (i_clk),
    .i_rst           (i_rst),
    .i_lsu_cmd_valid (lsu_w_cmd_valid),
    .o_lsu_cmd_ready (lsu_w_cmd_ready),
    .i_lsu_cmd_addr  (lsu_w_cmd_addr),
    .i_lsu_cmd_read  (lsu_w_cmd_read),
    .i_lsu_cmd_wdata (lsu_w_cmd_wdata),
    .i_lsu_cmd_wmask (lsu_w_cmd_wmask),
    .o_lsu_rsp_valid (lsu_w_rsp_valid),
    .i_lsu_rsp_ready (lsu_w_rsp_ready),
    .o_lsu_rsp_rdata (lsu_w_rsp_rdata),
    .i_ifu_cmd_valid (i_ifu_cmd_valid),
    .o_ifu_cmd_ready (o_ifu_cmd_ready),
    .i_ifu_cmd_addr  (i_ifu_cmd_addr),
    .i_ifu_cmd_read  (i_ifu_cmd_read),
    .i_ifu_cmd_wdata (i_ifu_cmd_wdata),
    .i_ifu_cmd_wmask (i_ifu_cmd_wmask),
    .o_ifu_rsp_valid (o_ifu_rsp_valid),
    .i_ifu_rsp_ready (i_ifu_rsp_ready),
    .o_ifu_rsp_rdata (o_ifu_rsp_rdata),
    .o_ifu_holdup    (o_ifu_holdup),
    .o_cmd_valid     (arb_cmd_valid),
    .i_cmd_ready     (arb_cmd_ready),
    .o_cmd_addr      (arb_cmd_addr),
    .o_cmd_read      (arb_cmd_read),
    .o_cmd_wdata     (arb_cmd_wdata),
    .o_cmd_wmask     (arb_cmd_wmask),
    .o_cmd_ifu       (arb_cmd_ifu),
    .i_rsp_valid     (arb_rsp_valid),
    .o_rsp_ready     (arb_rsp_ready),
    .i_rsp_rdata     (arb_rsp_rdata),
    .i_rsp_ifu       (arb_rsp_ifu)
  );

  itcm_sram_ctrl u_sram_ctrl (
    .i_clk           (i_clk),
    .i_rst           (i_rst),
    .i_cmd_valid     (arb_cmd_valid),
    .o_cmd_ready     (arb_cmd_ready),
    .i_cmd_addr      (arb_cmd_addr),
    .i_cmd_read      (arb_cmd_read),
    .i_cmd_wdata     (arb_cmd_wdata),
    .i_cmd_wmask     (arb_cmd_wmask),
    .i_cmd_ifu       (arb_cmd_ifu),
    .o_rsp_valid     (arb_rsp_valid),
    .i_rsp_ready     (arb_rsp_ready),
    .o_rsp_rdata     (arb_rsp_rdata),
    .o_rsp_ifu       (arb_rsp_ifu),
    .o_ram_cs        (o_ram_cs),
    .o_ram_we        (o_ram_we),
    .o_ram_addr      (o_ram_addr),
    .o_ram_wem       (o_ram_wem),
    .o_ram_din       (o_ram_din),
    .i_ram_dout      (i_ram_dout),
    .i_lsu_cmd_valid (i_lsu_cmd_valid),  // Raw valids, before the converter
    .i_ifu_cmd_valid (i_ifu_cmd_valid),
    .o_active        (o_itcm_active)
  );

endmodule

`default_nettype wire

//--- itcm_ram/itcm_sram_ctrl.sv
// Single-port RAM pin controller for the ITCM
// One transaction at a time, response held until accepted
// RAM read data is expected one cycle after cs
`timescale 1ns/1ps
`default_nettype none

`include "itcm_defines.svh"

module itcm_sram_ctrl (
  input  wire                          i_clk,
  input  wire                          i_rst,
  // Command in
  input  wire                          i_cmd_valid,
  output logic                         o_cmd_ready,
  input  wire [`ITCM_ADDR_WIDTH-1:0]   i_cmd_addr,
  input  wire                          i_cmd_read,
  input  wire itcm_pkg::itcm_word_u    i_cmd_wdata,
  input  wire [`ITCM_WMSK_WIDTH-1:0]   i_cmd_wmask,
  input  wire                          i_cmd_ifu,
  // Response out
  output logic                         o_rsp_valid,
  input  wire                          i_rsp_ready,
  output itcm_pkg::itcm_word_u         o_rsp_rdata,
  output logic                         o_rsp_ifu,
  // RAM pins
  output logic                         o_ram_cs,
  output logic                         o_ram_we,
  output logic [`ITCM_RAM_AW-1:0]      o_ram_addr,
  output logic [`ITCM_WMSK_WIDTH-1:0]  o_ram_wem,
  output logic [`ITCM_DATA_WIDTH-1:0]  o_ram_din,
  input  wire [`ITCM_DATA_WIDTH-1:0]   i_ram_dout,
  // Status
  input  wire                          i_lsu_cmd_valid,
  input  wire                          i_ifu_cmd_valid,
  output logic                         o_active
);

  logic pend_r;     // Response waiting for its ready
  logic tag_r;      // Source of the pending response
  logic cmd_xfer;
  logic rsp_xfer;

  assign rsp_xfer    = pend_r & i_rsp_ready;
  assign o_cmd_ready = ~pend_r | i_rsp_ready;  // Back-to-back when drained
  assign cmd_xfer    = i_cmd_valid & o_cmd_ready;

  ////////////////////////////////////////////////////////////////////////////
  // RAM access in the transfer cycle
  ////////////////////////////////////////////////////////////////////////////
  assign o_ram_cs   = cmd_xfer;
  assign o_ram_we   = cmd_xfer & ~i_cmd_read;
  assign o_ram_addr = i_cmd_addr[`ITCM_ADDR_WIDTH-1:`ITCM_AW_LSB];  // Word index
  assign o_ram_wem  = i_cmd_wmask;
  assign o_ram_din  = i_cmd_wdata.word;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      pend_r <= 1'b0;
      tag_r  <= 1'b0;
    end else if (cmd_xfer) begin
      pend_r <= 1'b1;
      tag_r  <= i_cmd_ifu;
    end else if (rsp_xfer) begin
      pend_r <= 1'b0;
    end
  end

  // RAM output stays put while no cs is issued
  assign o_rsp_valid = pend_r;
  assign o_rsp_rdata = i_ram_dout;
  assign o_rsp_ifu   = tag_r;

  assign o_active = i_lsu_cmd_valid | i_ifu_cmd_valid | pend_r;

  // Stalled response keeps its word on the RAM output
  a_rdata_held : assert property (@(posedge i_clk) disable iff (i_rst)
    (o_rsp_valid && !i_rsp_ready) |=> (o_rsp_valid && $stable(o_rsp_rdata)));

endmodule

`default_nettype wire

//--- itcm_ram/itcm_arbiter.sv
// Fixed-priority arbiter between LSU and IFU for the ITCM RAM
// Tags each granted command and routes the response back by that tag
// Also keeps the IFU holdup flag
`timescale 1ns/1ps
`default_nettype none

`include "itcm_defines.svh"

module itcm_arbiter (
  input  wire                          i_clk,
  input  wire                          i_rst,
  // LSU side, already in lane form
  input  wire                          i_lsu_cmd_valid,
  output logic                         o_lsu_cmd_ready,
  input  wire [`ITCM_ADDR_WIDTH-1:0]   i_lsu_cmd_addr,
  input  wire                          i_lsu_cmd_read,
  input  wire itcm_pkg::itcm_word_u    i_lsu_cmd_wdata,
  input  wire [`ITCM_WMSK_WIDTH-1:0]   i_lsu_cmd_wmask,
  output logic                         o_lsu_rsp_valid,
  input  wire                          i_lsu_rsp_ready,
  output itcm_pkg::itcm_word_u         o_lsu_rsp_rdata,
  // IFU side
  input  wire                          i_ifu_cmd_valid,
  output logic                         o_ifu_cmd_ready,
  input  wire [`ITCM_ADDR_WIDTH-1:0]   i_ifu_cmd_addr,
  input  wire                          i_ifu_cmd_read,
  input  wire itcm_pkg::itcm_word_u    i_ifu_cmd_wdata,
  input  wire [`ITCM_WMSK_WIDTH-1:0]   i_ifu_cmd_wmask,
  output logic                         o_ifu_rsp_valid,
  input  wire                          i_ifu_rsp_ready,
  output itcm_pkg::itcm_word_u         o_ifu_rsp_rdata,
  output logic                         o_ifu_holdup,
  // To the RAM controller
  output logic                         o_cmd_valid,
  input  wire                          i_cmd_ready,
  output logic [`ITCM_ADDR_WIDTH-1:0]  o_cmd_addr,
  output logic                         o_cmd_read,
  output itcm_pkg::itcm_word_u         o_cmd_wdata,
  output logic [`ITCM_WMSK_WIDTH-1:0]  o_cmd_wmask,
  output logic                         o_cmd_ifu,
  input  wire                          i_rsp_valid,
  output logic                         o_rsp_ready,
  input  wire itcm_pkg::itcm_word_u    i_rsp_rdata,
  input  wire                          i_rsp_ifu
);

  logic sel_ifu;      // IFU granted this cycle
  logic cmd_xfer;
  logic holdup_r;

  ////////////////////////////////////////////////////////////////////////////
  // Command grant and mux
  ////////////////////////////////////////////////////////////////////////////
  assign sel_ifu = ~i_lsu_cmd_valid;   // LSU always wins

  assign o_lsu_cmd_ready = i_cmd_ready;
  assign o_ifu_cmd_ready = i_cmd_ready & sel_ifu;

  assign o_cmd_valid = i_lsu_cmd_valid | i_ifu_cmd_valid;
  assign o_cmd_addr  = sel_ifu ? i_ifu_cmd_addr  : i_lsu_cmd_addr;
  assign o_cmd_read  = sel_ifu ? i_ifu_cmd_read  : i_lsu_cmd_read;
  assign o_cmd_wdata = sel_ifu ? i_ifu_cmd_wdata : i_lsu_cmd_wdata;
  assign o_cmd_wmask = sel_ifu ? i_ifu_cmd_wmask : i_lsu_cmd_wmask;
  assign o_cmd_ifu   = sel_ifu;

  assign cmd_xfer = o_cmd_valid & i_cmd_ready;

  ////////////////////////////////////////////////////////////////////////////
  // Response steering by returned tag
  ////////////////////////////////////////////////////////////////////////////
  assign o_ifu_rsp_valid = i_rsp_valid & i_rsp_ifu;
  assign o_lsu_rsp_valid = i_rsp_valid & ~i_rsp_ifu;
  assign o_ifu_rsp_rdata = i_rsp_rdata;   // Same word to both, valid qualifies
  assign o_lsu_rsp_rdata = i_rsp_rdata;
  assign o_rsp_ready     = i_rsp_ifu ? i_ifu_rsp_ready : i_lsu_rsp_ready;

  // Holdup
  // Set by an IFU access, cleared by any LSU access
  // Idle cycles keep it since the RAM output does not change
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      holdup_r <= 1'b0;
    end else if (cmd_xfer) begin
      holdup_r <= sel_ifu;
    end
  end

  assign o_ifu_holdup = holdup_r;

  // Response one cycle after the grant, routed back to the granted side
  a_tag_return : assert property (@(posedge i_clk) disable iff (i_rst)
    (o_cmd_valid && i_cmd_ready) |=> (i_rsp_valid && (i_rsp_ifu == $past(o_cmd_ifu))));

endmodule

`default_nettype wire

//--- source/itcm_lsu_n2w.sv
// LSU narrow-to-wide converter
// Places 32-bit LSU writes into one lane of the 64-bit word
// and returns the matching lane of the read word
`timescale 1ns/1ps
`default_nettype none

`include "itcm_defines.svh"

module itcm_lsu_n2w (
  input  wire                          i_clk,
  input  wire                          i_rst,
  // Narrow side, from the LSU
  input  wire                          i_cmd_valid,
  output logic                         o_cmd_ready,
  input  wire [`ITCM_ADDR_WIDTH-1:0]   i_cmd_addr,
  input  wire                          i_cmd_read,
  input  wire [`LSU_DATA_WIDTH-1:0]    i_cmd_wdata,
  input  wire [`LSU_WMSK_WIDTH-1:0]    i_cmd_wmask,
  output logic                         o_rsp_valid,
  input  wire                          i_rsp_ready,
  output logic [`LSU_DATA_WIDTH-1:0]   o_rsp_rdata,
  // Wide side, to the arbiter
  output logic                         o_cmd_valid,
  input  wire                          i_cmd_ready,
  output logic [`ITCM_ADDR_WIDTH-1:0]  o_cmd_addr,
  output logic                         o_cmd_read,
  output itcm_pkg::itcm_word_u         o_cmd_wdata,
  output logic [`ITCM_WMSK_WIDTH-1:0]  o_cmd_wmask,
  input  wire                          i_rsp_valid,
  output logic                         o_rsp_ready,
  input  wire itcm_pkg::itcm_word_u    i_rsp_rdata
);

  logic lane_sel;   // Address bit 2 of the current command
  logic lane_r;     // Lane of the response we owe
  logic owed_r;     // A response is still owed to the LSU
  logic cmd_xfer;
  logic rsp_xfer;

  assign lane_sel = i_cmd_addr[`ITCM_AW_LSB-1];
  assign cmd_xfer = i_cmd_valid & i_cmd_ready;
  assign rsp_xfer = i_rsp_valid & i_rsp_ready;

  // Handshakes pass straight through
  assign o_cmd_valid = i_cmd_valid;
  assign o_cmd_ready = i_cmd_ready;
  assign o_rsp_valid = i_rsp_valid;
  assign o_rsp_ready = i_rsp_ready;
  assign o_cmd_addr  = i_cmd_addr;
  assign o_cmd_read  = i_cmd_read;

  // Same data in both lanes, the mask picks which one gets written
  always_comb begin
    o_cmd_wdata.lane[0] = i_cmd_wdata;
    o_cmd_wdata.lane[1] = i_cmd_wdata;
    if (lane_sel) begin
      o_cmd_wmask = {i_cmd_wmask, {`LSU_WMSK_WIDTH{1'b0}}};  // Upper lane
    end else begin
      o_cmd_wmask = {{`LSU_WMSK_WIDTH{1'b0}}, i_cmd_wmask};  // Lower lane
    end
  end

  assign o_rsp_rdata = i_rsp_rdata.lane[lane_r];

  always_ff @(posedge i_clk) begin
    if (cmd_xfer) begin
      lane_r <= lane_sel;  // Payload, no reset needed
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      owed_r <= 1'b0;
    end else if (cmd_xfer) begin
      owed_r <= 1'b1;
    end else if (rsp_xfer) begin
      owed_r <= 1'b0;
    end
  end

  // Only one LSU transaction in flight, lane_r must not be overwritten early
  a_single_outstanding : assert property (@(posedge i_clk) disable iff (i_rst)
    (cmd_xfer && owed_r) |-> rsp_xfer);

endmodule

`default_nettype wire

//--- common/itcm_pkg.sv
// Types shared by the ITCM controller blocks
// Import where the 64-bit word is used in two views
`default_nettype none

`include "itcm_defines.svh"

package itcm_pkg;

  // One RAM word, seen whole or split into two 32-bit lanes
  typedef union packed {
    logic [`ITCM_DATA_WIDTH-1:0]    word;  // Full word for IFU and RAM
    logic [1:0][`LSU_DATA_WIDTH-1:0] lane; // lane[0] is the low half
  } itcm_word_u;

endpackage

`default_nettype wire

//--- common/itcm_defines.svh
// Width and depth macros for the ITCM controller
// Include in any file that sizes a port or a word of the ITCM path
`ifndef ITCM_DEFINES_SVH
`define ITCM_DEFINES_SVH

////////////////////////////////////////////////////////////////////////////
// RAM side
////////////////////////////////////////////////////////////////////////////
`define ITCM_ADDR_WIDTH 16   // Byte address, 64 KiB
`define ITCM_DATA_WIDTH 64   // One RAM word
`define ITCM_WMSK_WIDTH 8    // Byte enables per RAM word
`define ITCM_AW_LSB     3    // Byte offset bits below the word index
`define ITCM_RAM_AW     13   // Word index into the RAM

// Lane select is address bit ITCM_AW_LSB-1
// 0 picks the lower 32 bits and 1 the upper 32 bits

////////////////////////////////////////////////////////////////////////////
// LSU side
////////////////////////////////////////////////////////////////////////////
`define LSU_DATA_WIDTH  32   // Narrow data port
`define LSU_WMSK_WIDTH  4    // Narrow byte enables

`endif
